/* hdr_ddr.f */
hw/ddr_pkg.sv
hw/ddr_mode_if.sv
hw/ddr_regf.sv
hw/ddr_mode.sv
hw/ddr_tx.sv
hw/ddr_rx.sv
hw/ddr_top.sv
testbench/ddr_checker.sv
testbench/ddr_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := ddr_tb
FILELIST   := hdr_ddr.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/ddr_tb.sv */
`default_nettype none

module ddr_tb;

  localparam int N_XFERS    = 16;
  localparam int WAIT_LIMIT = 1000;

  logic        sys_clk;
  logic        sys_rst;
  logic        engine_en;
  logic        rnw;
  logic [6:0]  cmd;
  logic [6:0]  addr;
  logic [2:0]  word_cnt;
  logic        regf_wr;
  logic [2:0]  regf_addr;
  logic [15:0] regf_wdata;
  logic [2:0]  regf_rd_addr;
  logic [15:0] regf_rdata;
  logic        sda_in;
  logic        scl;
  logic        sda_out;
  logic        sda_oe;
  logic        busy;
  logic        engine_done;
  logic        parity_err;
  logic [63:0] exp_words;
  logic        exp_err;
  int          chk_errors;
  int          tb_errors;
  logic        timed_out;

  ddr_top ddr_top_inst (
    .i_sys_clk      (sys_clk),
    .i_sys_rst      (sys_rst),
    .i_engine_en    (engine_en),
    .i_rnw          (rnw),
    .i_cmd          (cmd),
    .i_addr         (addr),
    .i_word_cnt     (word_cnt),
    .i_regf_wr      (regf_wr),
    .i_regf_addr    (regf_addr),
    .i_regf_wdata   (regf_wdata),
    .i_regf_rd_addr (regf_rd_addr),
    .o_regf_rdata   (regf_rdata),
    .i_sda          (sda_in),
    .o_scl          (scl),
    .o_sda          (sda_out),
    .o_sda_oe       (sda_oe),
    .o_busy         (busy),
    .o_engine_done  (engine_done),
    .o_parity_err   (parity_err)
  );

  ddr_checker ddr_checker_inst (
    .i_sys_clk      (sys_clk),
    .i_sys_rst      (sys_rst),
    .i_engine_en    (engine_en),
    .i_rnw          (rnw),
    .i_cmd          (cmd),
    .i_addr         (addr),
    .i_word_cnt     (word_cnt),
    .i_regf_wr      (regf_wr),
    .i_regf_addr    (regf_addr),
    .i_regf_wdata   (regf_wdata),
    .i_regf_rd_addr (regf_rd_addr),
    .i_regf_rdata   (regf_rdata),
    .i_sda          (sda_in),
    .i_scl          (scl),
    .i_sda_out      (sda_out),
    .i_sda_oe       (sda_oe),
    .i_busy         (busy),
    .i_engine_done  (engine_done),
    .i_parity_err   (parity_err),
    .i_exp_words    (exp_words),
    .i_exp_err      (exp_err),
    .o_err_cnt      (chk_errors)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  task automatic note_timeout(input string what);
    $display("%0t: timeout, %s did not happen within %0d cycles", $time, what, WAIT_LIMIT);
    timed_out = 1'b1;
    tb_errors++;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && !timed_out) begin
      @(negedge sys_clk);
      n++;
      if (n > WAIT_LIMIT) note_timeout("end of frame");
    end
  endtask

  task automatic wait_sda_released();
    int n;
    n = 0;
    while (sda_oe && !timed_out) begin
      @(negedge sys_clk);
      n++;
      if (n > WAIT_LIMIT) note_timeout("SDA release for read data");
    end
  endtask

  task automatic wait_scl_change();
    logic prev;
    int   n;
    prev = scl;
    n    = 0;
    while (scl == prev && !timed_out) begin
      @(negedge sys_clk);
      n++;
      if (n > WAIT_LIMIT) note_timeout("an SCL edge");
    end
  endtask

  task automatic host_write(input logic [2:0] a, input logic [15:0] d);
    regf_wr    = 1'b1;
    regf_addr  = a;
    regf_wdata = d;
    @(negedge sys_clk);
    regf_wr = 1'b0;
  endtask

  task automatic start_transfer(input logic dir, input logic [6:0] c, input logic [6:0] a,
                                input logic [2:0] n);
    rnw       = dir;
    cmd       = c;
    addr      = a;
    word_cnt  = n;
    engine_en = 1'b1;
    @(negedge sys_clk);
    engine_en = 1'b0;
  endtask

  // target side of a read, one bit per scl change
  task automatic drive_read_words(input int n, input int bad_word, input int bad_bit);
    logic [19:0] frame;
    logic [15:0] w;
    logic        pa1;
    logic        pa0;
    wait_sda_released();
    for (int i = 0; i < n; i++) begin
      w   = exp_words[16*i +: 16];
      pa1 = 1'b0;
      pa0 = 1'b1;                                 // inverted even parity
      for (int k = 0; k < 16; k += 2) begin
        pa0 = pa0 ^ w[k];
        pa1 = pa1 ^ w[k+1];
      end
      frame = {2'b10, w, pa1, pa0};
      if (i == bad_word) begin
        frame[bad_bit] = ~frame[bad_bit];
      end
      for (int b = 19; b >= 0; b--) begin
        sda_in = frame[b];
        wait_scl_change();
      end
    end
    sda_in = 1'b1;
  endtask

  initial begin
    logic       dir;
    logic [6:0] cmd_v;
    logic [6:0] addr_v;
    logic [2:0] cnt_v;
    int         bad_word;
    int         seed;
    sys_rst      = 1'b0;
    engine_en    = 1'b0;
    rnw          = 1'b0;
    cmd          = '0;
    addr         = '0;
    word_cnt     = '0;
    regf_wr      = 1'b0;
    regf_addr    = '0;
    regf_wdata   = '0;
    regf_rd_addr = '0;
    sda_in       = 1'b1;
    exp_words    = '0;
    exp_err      = 1'b0;
    tb_errors    = 0;
    timed_out    = 1'b0;
    seed         = 25;
    void'($urandom(seed));
    repeat (4) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst = 1'b1;
    repeat (3) @(negedge sys_clk);
    for (int t = 0; t < N_XFERS && !timed_out; t++) begin
      dir      = (t == 0) ? 1'b0 : ((t < 3) ? 1'b1 : 1'($urandom % 2));
      cmd_v    = 7'($urandom);
      addr_v   = 7'($urandom);
      cnt_v    = 3'($urandom % 4) + 3'd1;
      bad_word = -1;
      exp_err  = 1'b0;
      if (!dir) begin
        for (int i = 0; i < int'(cnt_v); i++) begin
          host_write(3'(i), 16'($urandom));
        end
      end else begin
        for (int i = 0; i < 4; i++) begin
          exp_words[16*i +: 16] = 16'($urandom);
        end
        if (t == 2 || (t > 2 && $urandom % 3 == 0)) begin
          bad_word = int'($urandom % 32'(cnt_v));
          exp_err  = 1'b1;
        end
      end
      start_transfer(dir, cmd_v, addr_v, cnt_v);
      if (dir) begin
        drive_read_words(int'(cnt_v), bad_word, int'($urandom % 2));
      end else if (t % 4 == 0) begin
        repeat (8) @(negedge sys_clk);
        start_transfer(1'b1, ~cmd_v, addr_v, 3'd1);  // lands mid frame
      end
      wait_idle();
      for (int i = 0; i < int'(cnt_v); i++) begin
        regf_rd_addr = 3'(i);
        repeat (2) @(negedge sys_clk);
      end
    end
    repeat (4) @(negedge sys_clk);
    $display("errors: checker %0d, testbench %0d (seed %0d)", chk_errors, tb_errors, seed);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/ddr_checker.sv */
`default_nettype none

module ddr_checker (
  input  logic        i_sys_clk,
  input  logic        i_sys_rst,
  input  logic        i_engine_en,
  input  logic        i_rnw,
  input  logic [6:0]  i_cmd,
  input  logic [6:0]  i_addr,
  input  logic [2:0]  i_word_cnt,
  input  logic        i_regf_wr,
  input  logic [2:0]  i_regf_addr,
  input  logic [15:0] i_regf_wdata,
  input  logic [2:0]  i_regf_rd_addr,
  input  logic [15:0] i_regf_rdata,
  input  logic        i_sda,
  input  logic        i_scl,
  input  logic        i_sda_out,
  input  logic        i_sda_oe,
  input  logic        i_busy,
  input  logic        i_engine_done,
  input  logic        i_parity_err,
  input  logic [63:0] i_exp_words,
  input  logic        i_exp_err,
  output int          o_err_cnt
);

  logic [15:0] regf_m [8];
  logic        bits [$];
  logic        exp_bits [$];
  logic        rst_q;
  logic        sda_in_q;
  logic        en_q;
  logic        rnw_q;
  logic        wr_q;
  logic [6:0]  cmd_q;
  logic [6:0]  addr_q;
  logic [2:0]  cnt_q;
  logic [2:0]  wr_addr_q;
  logic [15:0] wr_data_q;
  logic [2:0]  rd_addr_q;
  logic [15:0] rdata_q;
  logic        prev_scl;
  logic        prev_oe;
  logic        frame_active;
  logic        seen_start;
  logic        f_rnw;
  logic [6:0]  f_cmd;
  logic [6:0]  f_addr;
  int          f_cnt;
  int          errors = 0;

  assign o_err_cnt = errors;

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic logic [1:0] parity_bits(input logic [15:0] w);
    logic pa1;
    logic pa0;
    pa1 = 1'b0;
    pa0 = 1'b1;                                   // even side is inverted
    for (int i = 0; i < 16; i++) begin
      if (i % 2 == 1) begin
        pa1 = pa1 ^ w[i];
      end else begin
        pa0 = pa0 ^ w[i];
      end
    end
    return {pa1, pa0};
  endfunction

  // x^5 + x^2 + 1, msb first
  function automatic logic [4:0] crc5_step(input logic [4:0] c, input logic d);
    logic fb;
    fb = c[4] ^ d;
    return {c[3], c[2], c[1] ^ fb, c[0], fb};
  endfunction

  task automatic push_word(input logic [1:0] pre, input logic [15:0] w);
    logic [1:0] par;
    par = parity_bits(w);
    exp_bits.push_back(pre[1]);
    exp_bits.push_back(pre[0]);
    for (int k = 15; k >= 0; k--) begin
      exp_bits.push_back(w[k]);
    end
    exp_bits.push_back(par[1]);
    exp_bits.push_back(par[0]);
  endtask

  task automatic check_frame();
    logic [4:0]  crc;
    logic [10:0] crc_word;
    logic [15:0] w;
    int          n_exp;
    exp_bits.delete();
    push_word(2'b01, {f_rnw, f_cmd, f_addr, 1'b0});
    n_exp = 20 * (1 + f_cnt);
    if (!f_rnw) begin
      crc = 5'b11111;
      for (int i = 0; i < f_cnt; i++) begin
        push_word(2'b10, regf_m[i]);
        for (int b = 15; b >= 0; b--) begin
          crc = crc5_step(crc, regf_m[i][b]);
        end
      end
      crc_word = {2'b01, 4'b1100, crc};
      for (int k = 10; k >= 0; k--) begin
        exp_bits.push_back(crc_word[k]);
      end
      n_exp = n_exp + 11;
    end
    if (bits.size() != n_exp) begin
      report_fail($sformatf("frame had %0d bits, expected %0d", bits.size(), n_exp));
    end else begin
      for (int i = 0; i < exp_bits.size(); i++) begin
        if (bits[i] !== exp_bits[i]) begin
          report_fail($sformatf("frame bit %0d is %b, expected %b", i, bits[i], exp_bits[i]));
          break;
        end
      end
      for (int i = 0; i < f_cnt && f_rnw; i++) begin
        for (int k = 0; k < 16; k++) begin
          w[15-k] = bits[20 * (i + 1) + 2 + k];
        end
        if (w !== i_exp_words[16*i +: 16]) begin
          report_fail($sformatf("read word %0d on bus is %h, expected %h", i, w,
                                i_exp_words[16*i +: 16]));
        end
      end
    end
    for (int i = 0; i < f_cnt && f_rnw; i++) begin
      regf_m[i] = i_exp_words[16*i +: 16];          // engine writes even on bad parity
    end
    if (i_parity_err !== (f_rnw & i_exp_err)) begin
      report_fail($sformatf("parity error flag is %b at done, expected %b", i_parity_err,
                            f_rnw & i_exp_err));
    end
  endtask

  always @(posedge i_sys_clk) begin
    rst_q     <= i_sys_rst;
    sda_in_q  <= i_sda;                             // target bit as the receiver sees it
    en_q      <= i_engine_en;
    rnw_q     <= i_rnw;
    cmd_q     <= i_cmd;
    addr_q    <= i_addr;
    cnt_q     <= i_word_cnt;
    wr_q      <= i_regf_wr;
    wr_addr_q <= i_regf_addr;
    wr_data_q <= i_regf_wdata;
    rd_addr_q <= i_regf_rd_addr;
    rdata_q   <= i_regf_rdata;
  end

  always @(negedge i_sys_clk) begin
    if (!rst_q) begin
      for (int i = 0; i < 8; i++) begin
        regf_m[i] = '0;
      end
      bits.delete();
      frame_active = 1'b0;
      seen_start   = 1'b0;
    end else begin
      if (!frame_active && rdata_q !== regf_m[rd_addr_q]) begin
        report_fail($sformatf("host read of entry %0d gave %h, expected %h", rd_addr_q,
                              rdata_q, regf_m[rd_addr_q]));
      end
      if (wr_q) begin
        regf_m[wr_addr_q] = wr_data_q;
      end
      if (en_q && !frame_active) begin
        frame_active = 1'b1;
        seen_start   = 1'b1;
        f_rnw        = rnw_q;
        f_cmd        = cmd_q;
        f_addr       = addr_q;
        f_cnt        = int'(cnt_q);
        bits.delete();
      end
      if (frame_active && i_scl != prev_scl) begin
        bits.push_back(prev_oe ? i_sda_out : sda_in_q);
      end
      if (i_engine_done) begin
        if (!frame_active) begin
          report_fail("done pulse without an accepted start");
        end else begin
          check_frame();
        end
        frame_active = 1'b0;
      end
      if (i_busy !== frame_active) begin
        report_fail($sformatf("busy is %b, expected %b", i_busy, frame_active));
      end
    end
    if (!seen_start && {i_scl, i_sda_out, i_sda_oe, i_busy, i_engine_done, i_parity_err}
        !== 6'b111000) begin
      report_fail("bus pins or status wrong before the first start");
    end
    prev_scl = rst_q ? i_scl : 1'b1;
    prev_oe  = rst_q ? i_sda_oe : 1'b1;
  end

endmodule

`default_nettype wire

/* hw/ddr_top.sv */
`default_nettype none

module ddr_top (
  input  logic                           i_sys_clk,
  input  logic                           i_sys_rst,
  input  logic                           i_engine_en,
  input  logic                           i_rnw,
  input  logic [ddr_pkg::DDR_CMD_W-1:0]  i_cmd,
  input  logic [ddr_pkg::DDR_CMD_W-1:0]  i_addr,
  input  logic [ddr_pkg::DDR_WCNT_W-1:0] i_word_cnt,
  input  logic                           i_regf_wr,
  input  logic [ddr_pkg::REGF_AW-1:0]    i_regf_addr,
  input  ddr_pkg::word_t                 i_regf_wdata,
  input  logic [ddr_pkg::REGF_AW-1:0]    i_regf_rd_addr,
  output ddr_pkg::word_t                 o_regf_rdata,
  input  logic                           i_sda,
  output logic                           o_scl,
  output logic                           o_sda,
  output logic                           o_sda_oe,
  output logic                           o_busy,
  output logic                           o_engine_done,
  output logic                           o_parity_err
);

  logic [ddr_pkg::REGF_AW-1:0] eng_addr;
  ddr_pkg::word_t              eng_rdata;
  ddr_pkg::word_t              eng_wdata;
  logic                        eng_wr;

  ddr_mode_if mode_bus ();

  ddr_regf ddr_regf_inst (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_host_wr    (i_regf_wr),
    .i_host_addr  (i_regf_addr),
    .i_host_wdata (i_regf_wdata),
    .i_eng_wr     (eng_wr),
    .i_eng_addr   (eng_addr),
    .i_eng_wdata  (eng_wdata),
    .i_rd_addr_a  (eng_addr),
    .o_rd_data_a  (eng_rdata),
    .i_rd_addr_b  (i_regf_rd_addr),
    .o_rd_data_b  (o_regf_rdata)
  );

  ddr_mode ddr_mode_inst (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_engine_en   (i_engine_en),
    .i_rnw         (i_rnw),
    .i_cmd         (i_cmd),
    .i_addr        (i_addr),
    .i_word_cnt    (i_word_cnt),
    .mode_if       (mode_bus.engine),
    .o_regf_addr   (eng_addr),
    .i_regf_rdata  (eng_rdata),
    .o_regf_wr_en  (eng_wr),
    .o_regf_wdata  (eng_wdata),
    .o_sda_oe      (o_sda_oe),
    .o_busy        (o_busy),
    .o_engine_done (o_engine_done),
    .o_parity_err  (o_parity_err)
  );

  ddr_tx ddr_tx_inst (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .mode_if   (mode_bus.tx),
    .o_scl     (o_scl),
    .o_sda     (o_sda)
  );

  ddr_rx ddr_rx_inst (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .i_sda     (i_sda),
    .mode_if   (mode_bus.rx)
  );

endmodule

`default_nettype wire

/* hw/ddr_rx.sv */
`default_nettype none

module ddr_rx (
  input  logic    i_sys_clk,
  input  logic    i_sys_rst,
  input  logic    i_sda,
  ddr_mode_if.rx  mode_if
);

  logic [ddr_pkg::DDR_WORD_BITS-2:0] shift_q;
  logic [ddr_pkg::DDR_BCNT_W-1:0]    bit_cnt_q;
  logic [ddr_pkg::DDR_WORD_BITS-1:0] word;
  logic                              last_edge;
  logic                              pre_bad;
  logic                              par_bad;

  // current bit joins the 19 already shifted in
  assign word      = {shift_q, i_sda};
  assign last_edge = mode_if.scl_edge && (bit_cnt_q == ddr_pkg::DDR_WORD_LAST);

  assign pre_bad = word[ddr_pkg::DDR_WORD_BITS-1 -: 2] != ddr_pkg::DDR_DATA_PRE;
  assign par_bad = word[1:0] != ddr_pkg::ddr_parity(mode_if.rx_word);

  assign mode_if.rx_word = word[ddr_pkg::DDR_WORD_BITS-3:2];
  assign mode_if.rx_err  = last_edge && (pre_bad || par_bad);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      bit_cnt_q <= '0;
    end else if (!mode_if.rx_en) begin
      bit_cnt_q <= '0;
    end else if (mode_if.scl_edge) begin
      bit_cnt_q <= last_edge ? '0 : bit_cnt_q + 1'b1;   // words back to back
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (mode_if.rx_en && mode_if.scl_edge) begin
      shift_q <= word[ddr_pkg::DDR_WORD_BITS-2:0];
    end
  end

endmodule

`default_nettype wire

/* hw/ddr_tx.sv */
`default_nettype none

module ddr_tx (
  input  logic    i_sys_clk,
  input  logic    i_sys_rst,
  ddr_mode_if.tx  mode_if,
  output logic    o_scl,
  output logic    o_sda
);

  logic [ddr_pkg::DDR_DIV_W-1:0]     div_q;
  logic [ddr_pkg::DDR_BCNT_W-1:0]    bit_cnt_q;
  logic [ddr_pkg::DDR_WORD_BITS-1:0] shift_q;
  logic [ddr_pkg::DDR_WORD_BITS-1:0] frame;
  logic [ddr_pkg::DDR_CRC_W-1:0]     crc_q;
  logic                              last_bit;
  logic                              crc_fb;
  logic                              pay_bit;

  assign mode_if.scl_edge  = mode_if.tx_en && (div_q == ddr_pkg::DDR_DIV_LAST);
  assign last_bit          = (mode_if.tx_mode == ddr_pkg::TX_CRC) ?
                             (bit_cnt_q == ddr_pkg::DDR_CRC_LAST) :
                             (bit_cnt_q == ddr_pkg::DDR_WORD_LAST);
  assign mode_if.mode_done = mode_if.scl_edge && last_bit;

  // crc word is left aligned, rest of frame unused
  always_comb begin
    case (mode_if.tx_mode)
      ddr_pkg::TX_CRC: frame = {ddr_pkg::DDR_CMD_PRE, ddr_pkg::DDR_CRC_TOKEN, crc_q,
                                {(ddr_pkg::DDR_WORD_BITS - ddr_pkg::DDR_CRC_BITS){1'b0}}};
      ddr_pkg::TX_DATA: frame = {ddr_pkg::DDR_DATA_PRE, mode_if.tx_word,
                                 ddr_pkg::ddr_parity(mode_if.tx_word)};
      default: frame = {ddr_pkg::DDR_CMD_PRE, mode_if.tx_word,
                        ddr_pkg::ddr_parity(mode_if.tx_word)};
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      div_q     <= '0;
      bit_cnt_q <= '0;
      o_scl     <= 1'b1;
      o_sda     <= 1'b1;
    end else if (!mode_if.tx_en) begin
      div_q     <= '0;
      bit_cnt_q <= '0;
      o_scl     <= 1'b1;                                  // park high between frames
      o_sda     <= 1'b1;
    end else begin
      div_q <= mode_if.scl_edge ? '0 : div_q + 1'b1;
      if (div_q == '0) begin
        o_sda <= (bit_cnt_q == '0) ? frame[ddr_pkg::DDR_WORD_BITS-1] :
                                     shift_q[ddr_pkg::DDR_WORD_BITS-1];
      end
      if (mode_if.scl_edge) begin
        o_scl     <= ~o_scl;
        bit_cnt_q <= last_bit ? '0 : bit_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (mode_if.tx_en && div_q == '0) begin
      if (bit_cnt_q == '0) begin
        shift_q <= {frame[ddr_pkg::DDR_WORD_BITS-2:0], 1'b0};   // word start
      end else begin
        shift_q <= {shift_q[ddr_pkg::DDR_WORD_BITS-2:0], 1'b0};
      end
    end
  end

  // msb first over data payload only
  assign pay_bit = (bit_cnt_q >= ddr_pkg::DDR_PAY_FIRST) && (bit_cnt_q <= ddr_pkg::DDR_PAY_LAST);
  assign crc_fb  = crc_q[ddr_pkg::DDR_CRC_W-1] ^ o_sda;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      crc_q <= ddr_pkg::DDR_CRC_INIT;
    end else if (mode_if.crc_clr) begin
      crc_q <= ddr_pkg::DDR_CRC_INIT;
    end else if (mode_if.scl_edge && mode_if.tx_mode == ddr_pkg::TX_DATA && pay_bit) begin
      crc_q <= {crc_q[ddr_pkg::DDR_CRC_W-2:0], 1'b0} ^ (crc_fb ? ddr_pkg::DDR_CRC_POLY : '0);
    end
  end

endmodule

`default_nettype wire

/* hw/ddr_mode.sv */
`default_nettype none

module ddr_mode (
  input  logic                           i_sys_clk,
  input  logic                           i_sys_rst,
  input  logic                           i_engine_en,
  input  logic                           i_rnw,
  input  logic [ddr_pkg::DDR_CMD_W-1:0]  i_cmd,
  input  logic [ddr_pkg::DDR_CMD_W-1:0]  i_addr,
  input  logic [ddr_pkg::DDR_WCNT_W-1:0] i_word_cnt,
  ddr_mode_if.engine                     mode_if,
  output logic [ddr_pkg::REGF_AW-1:0]    o_regf_addr,
  input  ddr_pkg::word_t                 i_regf_rdata,
  output logic                           o_regf_wr_en,
  output ddr_pkg::word_t                 o_regf_wdata,
  output logic                           o_sda_oe,
  output logic                           o_busy,
  output logic                           o_engine_done,
  output logic                           o_parity_err
);

  ddr_pkg::eng_state_t                state_q;
  ddr_pkg::eng_state_t                state_d;
  logic                               rnw_q;
  logic [ddr_pkg::DDR_WCNT_W-1:0]     cnt_q;
  logic [ddr_pkg::DDR_WIDX_W-1:0]     word_idx_q;
  logic                               parity_q;
  ddr_pkg::word_t                     cmd_word_q;
  logic                               start;
  logic                               last_word;
  logic                               rd_word;

  assign start     = i_engine_en && !o_busy;
  assign last_word = ({1'b0, word_idx_q} + 3'd1) == cnt_q;
  assign rd_word   = (state_q == ddr_pkg::ST_DATA) && rnw_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q    <= ddr_pkg::ST_IDLE;
      rnw_q      <= 1'b0;
      cnt_q      <= '0;
      word_idx_q <= '0;
      parity_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start) begin
        rnw_q      <= i_rnw;
        word_idx_q <= '0;
        parity_q   <= 1'b0;
        if (i_word_cnt == '0) begin
          cnt_q <= 3'd1;
        end else if (i_word_cnt > ddr_pkg::DDR_WCNT_MAX) begin
          cnt_q <= ddr_pkg::DDR_WCNT_MAX;                  // clamp to 4 words
        end else begin
          cnt_q <= i_word_cnt;
        end
      end else if (mode_if.mode_done && state_q == ddr_pkg::ST_DATA) begin
        if (!last_word) begin
          word_idx_q <= word_idx_q + 1'b1;
        end
        if (rd_word && mode_if.rx_err) begin
          parity_q <= 1'b1;                                // sticky until next start
        end
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (start) begin
      cmd_word_q <= {i_rnw, i_cmd, i_addr, 1'b0};
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ddr_pkg::ST_IDLE,
      ddr_pkg::ST_DONE: begin
        state_d = start ? ddr_pkg::ST_CMD : ddr_pkg::ST_IDLE;
      end
      ddr_pkg::ST_CMD: begin
        if (mode_if.mode_done) begin
          state_d = ddr_pkg::ST_DATA;
        end
      end
      ddr_pkg::ST_DATA: begin
        if (mode_if.mode_done && last_word) begin
          state_d = rnw_q ? ddr_pkg::ST_DONE : ddr_pkg::ST_CRC;  // no crc on reads
        end
      end
      ddr_pkg::ST_CRC: begin
        if (mode_if.mode_done) begin
          state_d = ddr_pkg::ST_DONE;
        end
      end
      default: begin
        state_d = ddr_pkg::ST_IDLE;
      end
    endcase
  end

  always_comb begin
    case (state_q)
      ddr_pkg::ST_DATA: mode_if.tx_mode = ddr_pkg::TX_DATA;
      ddr_pkg::ST_CRC:  mode_if.tx_mode = ddr_pkg::TX_CRC;
      default:          mode_if.tx_mode = ddr_pkg::TX_CMD;
    endcase
  end

  assign o_busy          = (state_q == ddr_pkg::ST_CMD) || (state_q == ddr_pkg::ST_DATA) ||
                           (state_q == ddr_pkg::ST_CRC);
  assign mode_if.tx_en   = o_busy;                         // scl runs for reads too
  assign mode_if.rx_en   = rd_word;
  assign mode_if.crc_clr = (state_q == ddr_pkg::ST_CMD);
  assign mode_if.tx_word = (state_q == ddr_pkg::ST_CMD) ? cmd_word_q : i_regf_rdata;

  assign o_regf_addr   = {1'b0, word_idx_q};
  assign o_regf_wr_en  = rd_word && mode_if.mode_done;
  assign o_regf_wdata  = mode_if.rx_word;
  assign o_sda_oe      = !rd_word;                         // target owns sda
  assign o_engine_done = (state_q == ddr_pkg::ST_DONE);
  assign o_parity_err  = parity_q;

endmodule

`default_nettype wire

/* hw/ddr_regf.sv */
`default_nettype none

module ddr_regf (
  input  logic                        i_sys_clk,
  input  logic                        i_sys_rst,
  input  logic                        i_host_wr,
  input  logic [ddr_pkg::REGF_AW-1:0] i_host_addr,
  input  ddr_pkg::word_t              i_host_wdata,
  input  logic                        i_eng_wr,
  input  logic [ddr_pkg::REGF_AW-1:0] i_eng_addr,
  input  ddr_pkg::word_t              i_eng_wdata,
  input  logic [ddr_pkg::REGF_AW-1:0] i_rd_addr_a,
  output ddr_pkg::word_t              o_rd_data_a,
  input  logic [ddr_pkg::REGF_AW-1:0] i_rd_addr_b,
  output ddr_pkg::word_t              o_rd_data_b
);

  ddr_pkg::word_t regs_q [ddr_pkg::REGF_DEPTH];

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      for (int i = 0; i < ddr_pkg::REGF_DEPTH; i++) begin
        regs_q[i] <= '0;
      end
    end else if (i_eng_wr) begin
      regs_q[i_eng_addr] <= i_eng_wdata;     // engine has priority
    end else if (i_host_wr) begin
      regs_q[i_host_addr] <= i_host_wdata;
    end
  end

  assign o_rd_data_a = regs_q[i_rd_addr_a];  // engine side
  assign o_rd_data_b = regs_q[i_rd_addr_b];  // host side

endmodule

`default_nettype wire

/* hw/ddr_mode_if.sv */
`default_nettype none

interface ddr_mode_if;

  logic              tx_en;       // held for whole word
  ddr_pkg::tx_mode_t tx_mode;
  ddr_pkg::word_t    tx_word;
  logic              rx_en;       // read data words only
  logic              crc_clr;
  logic              scl_edge;    // one cycle per scl toggle
  logic              mode_done;   // last edge of a word
  ddr_pkg::word_t    rx_word;
  logic              rx_err;

  modport engine (
    output tx_en, tx_mode, tx_word, rx_en, crc_clr,
    input  mode_done, rx_word, rx_err
  );

  modport tx (
    input  tx_en, tx_mode, tx_word, crc_clr,
    output scl_edge, mode_done
  );

  modport rx (
    input  rx_en, scl_edge,
    output rx_word, rx_err
  );

endinterface

`default_nettype wire

/* hw/ddr_pkg.sv */
`default_nettype none

package ddr_pkg;

  localparam int DDR_BIT_CYCLES = 4;      // sys clocks per bit time
  localparam int DDR_DIV_W      = 2;
  localparam int DDR_WORD_BITS  = 20;
  localparam int DDR_CRC_BITS   = 11;
  localparam int DDR_PAY_BITS   = 16;
  localparam int DDR_BCNT_W     = 5;
  localparam int DDR_CMD_W      = 7;
  localparam int DDR_WCNT_W     = 3;
  localparam int DDR_WIDX_W     = 2;
  localparam int DDR_CRC_W      = 5;
  localparam int REGF_DEPTH     = 8;
  localparam int REGF_AW        = 3;

  localparam logic [1:0] DDR_CMD_PRE   = 2'b01;   // command and crc words
  localparam logic [1:0] DDR_DATA_PRE  = 2'b10;
  localparam logic [3:0] DDR_CRC_TOKEN = 4'b1100;

  localparam logic [DDR_CRC_W-1:0] DDR_CRC_INIT = 5'b11111;
  localparam logic [DDR_CRC_W-1:0] DDR_CRC_POLY = 5'b00101;  // x^5 + x^2 + 1

  localparam logic [DDR_DIV_W-1:0]  DDR_DIV_LAST  = DDR_DIV_W'(DDR_BIT_CYCLES - 1);
  localparam logic [DDR_BCNT_W-1:0] DDR_WORD_LAST = DDR_BCNT_W'(DDR_WORD_BITS - 1);
  localparam logic [DDR_BCNT_W-1:0] DDR_CRC_LAST  = DDR_BCNT_W'(DDR_CRC_BITS - 1);
  localparam logic [DDR_BCNT_W-1:0] DDR_PAY_FIRST = 5'd2;    // after preamble
  localparam logic [DDR_BCNT_W-1:0] DDR_PAY_LAST  = 5'd17;   // before parity
  localparam logic [DDR_WCNT_W-1:0] DDR_WCNT_MAX  = 3'd4;

  localparam logic [DDR_PAY_BITS-1:0] DDR_ODD_MASK  = 16'hAAAA;
  localparam logic [DDR_PAY_BITS-1:0] DDR_EVEN_MASK = 16'h5555;

  typedef logic [DDR_PAY_BITS-1:0] word_t;

  typedef enum logic [1:0] {
    TX_CMD  = 2'd0,
    TX_DATA = 2'd1,
    TX_CRC  = 2'd2
  } tx_mode_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_DATA,
    ST_CRC,
    ST_DONE
  } eng_state_t;

  // pa1 over odd bits, pa0 over even bits inverted
  function automatic logic [1:0] ddr_parity(input word_t w);
    ddr_parity = {^(w & DDR_ODD_MASK), ~^(w & DDR_EVEN_MASK)};
  endfunction

endpackage

`default_nettype wire
